/* project.f */
transport_cfg_pkg.sv
transport_status_pkg.sv
stream_read_port.sv
byte_lane_buffer.sv
stream_write_port.sv
idma_stream_transport.sv
idma_stream_transport_sva.sv
tb_idma_stream_transport.sv

/* run.sh */
#!/bin/sh
# Builds the transport testbench with Verilator and runs it
# The exit status is nonzero when the build or the simulation fails

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert \
    -f project.f \
    --top-module tb_idma_stream_transport \
    -o tb_sim
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

./obj_dir/tb_sim
if [ $? -ne 0 ]; then
    echo "Simulation ended with an error"
    exit 1
fi

exit 0

/* tb_idma_stream_transport.sv */
// Random transfers from a fixed seed, checked against a byte-queue model
// Reads and writes run as separate processes so their requests overlap
// The run stops at the first mismatch

`timescale 1ns/1ps

module tb_idma_stream_transport
    import transport_cfg_pkg::*;
    import transport_status_pkg::*;
();

    localparam int unsigned NUM_XFERS    = 200;
    localparam int unsigned MAX_LEN      = 40;
    localparam int unsigned HALF_PERIOD  = 4;
    localparam int unsigned RESET_CYCLES = 10;
    // Budget of 60 clock cycles per transfer
    localparam int unsigned TIMEOUT_NS   = NUM_XFERS * 60 * 2 * HALF_PERIOD;

    logic    clk_i;
    logic    reset_i;
    offset_t r_req_offset_i;
    offset_t r_req_tailer_i;
    offset_t r_req_shift_i;
    beats_t  r_req_beats_i;
    logic    r_req_valid_i;
    logic    r_req_ready_o;
    status_t r_rsp_status_o;
    logic    r_rsp_valid_o;
    logic    r_rsp_ready_i;
    offset_t w_req_offset_i;
    offset_t w_req_tailer_i;
    beats_t  w_req_beats_i;
    logic    w_req_valid_i;
    logic    w_req_ready_o;
    logic    w_rsp_valid_o;
    logic    w_rsp_ready_i;
    data_t   src_data_i;
    logic    src_last_i;
    logic    src_valid_i;
    logic    src_ready_o;
    data_t   dst_data_o;
    strb_t   dst_strb_o;
    logic    dst_last_o;
    logic    dst_valid_o;
    logic    dst_ready_i;
    logic    r_busy_o;
    logic    w_busy_o;
    logic    buffer_busy_o;

    // Transfer list, shared by the read and write processes
    int unsigned src_off  [NUM_XFERS];
    int unsigned dst_off  [NUM_XFERS];
    int unsigned xfer_len [NUM_XFERS];
    int          last_at  [NUM_XFERS];

    // Bytes taken from the source and not yet seen at the destination
    byte_t       model_q [$];
    logic [31:0] lcg_state = 32'h9f2;

    // Response handshakes seen on the ports
    int unsigned rsp_r_count = 0;
    int unsigned rsp_w_count = 0;

    idma_stream_transport u_dut (.*);

    // ----------------------------------------
    // Helpers
    // ----------------------------------------
    function automatic logic [31:0] next_word();
        lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
        return lcg_state;
    endfunction

    function automatic int unsigned rand_below(int unsigned n);
        return (next_word() >> 8) % n;
    endfunction

    // Last beat index of a transfer that starts at lane off
    function automatic int unsigned beat_count(int unsigned off, int unsigned nbytes);
        return (off + nbytes - 1) / STRB_WIDTH;
    endfunction

    // Lanes of a beat that fall inside the transfer's byte range
    function automatic strb_t beat_mask(int unsigned off, int unsigned nbytes,
                                        int unsigned beat);
        strb_t       m;
        int unsigned pos;
        m = '0;
        for (int unsigned l = 0; l < STRB_WIDTH; l++) begin
            pos = beat * STRB_WIDTH + l;
            if (pos >= off && pos < off + nbytes) begin
                m = m | (strb_t'(1) << l);
            end
        end
        return m;
    endfunction

    task automatic abort_run();
        $display("Regression failed");
        $fatal(1, "Stopping at the first error");
    endtask

    task automatic check_value(string name, logic [31:0] expected, logic [31:0] actual);
        assert (actual === expected) else begin
            $display("FAILED at %0t ns: %s expected %0h, got %0h",
                     $time, name, expected, actual);
            abort_run();
        end
    endtask

    // ----------------------------------------
    // Read side: requests, source beats, status
    // ----------------------------------------
    task automatic run_reads();
        int unsigned beats;
        status_t     exp_status;
        strb_t       m;
        data_t       d;
        logic        last;
        for (int unsigned t = 0; t < NUM_XFERS; t++) begin
            beats = beat_count(src_off[t], xfer_len[t]);
            @(negedge clk_i);
            r_req_offset_i = offset_t'(src_off[t]);
            r_req_tailer_i = offset_t'((src_off[t] + xfer_len[t]) % STRB_WIDTH);
            r_req_shift_i  = offset_t'((src_off[t] + STRB_WIDTH - dst_off[t]) % STRB_WIDTH);
            r_req_beats_i  = beats_t'(beats);
            r_req_valid_i  = 1'b1;
            do @(posedge clk_i); while (!r_req_ready_o);
            exp_status = STATUS_OK;
            for (int unsigned b = 0; b <= beats; b++) begin
                @(negedge clk_i);
                r_req_valid_i = 1'b0;
                src_valid_i   = 1'b0;
                repeat (rand_below(2)) @(negedge clk_i);
                last        = (last_at[t] == int'(b));
                src_data_i  = next_word();
                src_last_i  = last;
                src_valid_i = 1'b1;
                do @(posedge clk_i); while (!src_ready_o);
                m = beat_mask(src_off[t], xfer_len[t], b);
                d = src_data_i;
                for (int unsigned l = 0; l < STRB_WIDTH; l++) begin
                    if (m[0]) begin
                        model_q.push_back(d[7:0]);
                    end
                    m = m >> 1;
                    d = d >> 8;
                end
                // First mismatch of the last mark decides the status
                if (exp_status == STATUS_OK) begin
                    if (last && b != beats) begin
                        exp_status = STATUS_EARLY_LAST;
                    end else if (!last && b == beats) begin
                        exp_status = STATUS_LATE_LAST;
                    end
                end
            end
            @(negedge clk_i);
            src_valid_i = 1'b0;
            do @(posedge clk_i); while (!(r_rsp_valid_o && r_rsp_ready_i));
            check_value("r_rsp_status_o", 32'(exp_status), 32'(r_rsp_status_o));
            // Busy until the response is taken
            check_value("r_busy_o", 32'd1, 32'(r_busy_o));
        end
    endtask

    // ----------------------------------------
    // Write side: requests, destination beats
    // ----------------------------------------
    task automatic run_writes();
        int unsigned beats;
        strb_t       mask;
        strb_t       m;
        data_t       d;
        byte_t       exp_byte;
        for (int unsigned t = 0; t < NUM_XFERS; t++) begin
            beats = beat_count(dst_off[t], xfer_len[t]);
            @(negedge clk_i);
            w_req_offset_i = offset_t'(dst_off[t]);
            w_req_tailer_i = offset_t'((dst_off[t] + xfer_len[t]) % STRB_WIDTH);
            w_req_beats_i  = beats_t'(beats);
            w_req_valid_i  = 1'b1;
            do @(posedge clk_i); while (!w_req_ready_o);
            @(negedge clk_i);
            w_req_valid_i = 1'b0;
            for (int unsigned b = 0; b <= beats; b++) begin
                do @(posedge clk_i); while (!(dst_valid_o && dst_ready_i));
                mask = beat_mask(dst_off[t], xfer_len[t], b);
                check_value("dst_strb_o", 32'(mask), 32'(dst_strb_o));
                check_value("dst_last_o", 32'(b == beats), 32'(dst_last_o));
                // The lanes of this beat still hold their bytes
                check_value("buffer_busy_o", 32'd1, 32'(buffer_busy_o));
                m = mask;
                d = dst_data_o;
                for (int unsigned l = 0; l < STRB_WIDTH; l++) begin
                    if (m[0]) begin
                        assert (model_q.size() != 0) else begin
                            $display("Destination sent a byte that the source never supplied");
                            abort_run();
                        end
                        exp_byte = model_q.pop_front();
                    end else begin
                        exp_byte = 8'h00;
                    end
                    check_value($sformatf("dst_data_o lane %0d", l),
                                32'(exp_byte), 32'(d[7:0]));
                    m = m >> 1;
                    d = d >> 8;
                end
            end
            do @(posedge clk_i); while (!(w_rsp_valid_o && w_rsp_ready_i));
            check_value("w_busy_o", 32'd1, 32'(w_busy_o));
        end
    endtask

    // ----------------------------------------
    // Clock, readies and watchdog
    // ----------------------------------------
    initial begin
        clk_i = 1'b0;
        forever #(HALF_PERIOD) clk_i = ~clk_i;
    end

    // Sink and response readies wander on their own
    initial begin
        dst_ready_i   = 1'b0;
        r_rsp_ready_i = 1'b0;
        w_rsp_ready_i = 1'b0;
        forever begin
            @(negedge clk_i);
            dst_ready_i   = (rand_below(4) != 0);
            r_rsp_ready_i = (rand_below(2) == 1);
            w_rsp_ready_i = (rand_below(2) == 1);
        end
    end

    // Every response handshake counts, expected or not
    always @(posedge clk_i) begin
        if (!reset_i && r_rsp_valid_o && r_rsp_ready_i) begin
            rsp_r_count++;
        end
        if (!reset_i && w_rsp_valid_o && w_rsp_ready_i) begin
            rsp_w_count++;
        end
    end

    initial begin
        #(TIMEOUT_NS);
        $display("Timeout: the transfers did not complete in time");
        abort_run();
    end

    // ----------------------------------------
    // Main sequence
    // ----------------------------------------
    initial begin
        reset_i        = 1'b1;
        r_req_offset_i = '0;
        r_req_tailer_i = '0;
        r_req_shift_i  = '0;
        r_req_beats_i  = '0;
        r_req_valid_i  = 1'b0;
        w_req_offset_i = '0;
        w_req_tailer_i = '0;
        w_req_beats_i  = '0;
        w_req_valid_i  = 1'b0;
        src_data_i     = '0;
        src_last_i     = 1'b0;
        src_valid_i    = 1'b0;

        // About one transfer in five gets a misplaced last mark
        for (int unsigned t = 0; t < NUM_XFERS; t++) begin
            src_off[t]  = rand_below(STRB_WIDTH);
            dst_off[t]  = rand_below(STRB_WIDTH);
            xfer_len[t] = 1 + rand_below(MAX_LEN);
            last_at[t]  = int'(beat_count(src_off[t], xfer_len[t]));
            if (rand_below(5) == 0) begin
                if (last_at[t] > 0 && rand_below(2) == 0) begin
                    last_at[t] = int'(rand_below(beat_count(src_off[t], xfer_len[t])));
                end else begin
                    last_at[t] = -1;
                end
            end
        end

        repeat (RESET_CYCLES) @(posedge clk_i);
        @(negedge clk_i);
        reset_i = 1'b0;
        check_value("r_rsp_valid_o", 32'd0, 32'(r_rsp_valid_o));
        check_value("w_rsp_valid_o", 32'd0, 32'(w_rsp_valid_o));
        check_value("dst_valid_o", 32'd0, 32'(dst_valid_o));
        check_value("src_ready_o", 32'd0, 32'(src_ready_o));
        check_value("r_busy_o", 32'd0, 32'(r_busy_o));
        check_value("w_busy_o", 32'd0, 32'(w_busy_o));
        check_value("buffer_busy_o", 32'd0, 32'(buffer_busy_o));
        check_value("r_req_ready_o", 32'd1, 32'(r_req_ready_o));
        check_value("w_req_ready_o", 32'd1, 32'(w_req_ready_o));

        fork
            run_reads();
            run_writes();
        join

        repeat (4) @(negedge clk_i);
        check_value("read responses", NUM_XFERS, rsp_r_count);
        check_value("write responses", NUM_XFERS, rsp_w_count);
        check_value("bytes left in model", 32'd0, 32'(model_q.size()));
        check_value("r_busy_o", 32'd0, 32'(r_busy_o));
        check_value("w_busy_o", 32'd0, 32'(w_busy_o));
        check_value("buffer_busy_o", 32'd0, 32'(buffer_busy_o));
        $display("Regression passed");
        $finish;
    end

endmodule

/* idma_stream_transport_sva.sv */
// Handshake checks bound into the transport top level
// Every valid holds with a stable payload until its transfer

`timescale 1ns/1ps

module idma_stream_transport_sva
    import transport_cfg_pkg::*;
    import transport_status_pkg::*;
(
    input logic    clk_i,
    input logic    reset_i,
    input data_t   src_data_i,
    input logic    src_last_i,
    input logic    src_valid_i,
    input logic    src_ready_o,
    input data_t   dst_data_o,
    input strb_t   dst_strb_o,
    input logic    dst_last_o,
    input logic    dst_valid_o,
    input logic    dst_ready_i,
    input status_t r_rsp_status_o,
    input logic    r_rsp_valid_o,
    input logic    r_rsp_ready_i,
    input logic    w_rsp_valid_o,
    input logic    w_rsp_ready_i
);

    src_hold: assert property (@(posedge clk_i) disable iff (reset_i)
        src_valid_i && !src_ready_o |=> src_valid_i && $stable({src_data_i, src_last_i}))
        else $error("Source beat dropped or changed before it was taken");

    dst_hold: assert property (@(posedge clk_i) disable iff (reset_i)
        dst_valid_o && !dst_ready_i |=>
            dst_valid_o && $stable({dst_data_o, dst_strb_o, dst_last_o}))
        else $error("Destination beat dropped or changed before it was taken");

    r_rsp_hold: assert property (@(posedge clk_i) disable iff (reset_i)
        r_rsp_valid_o && !r_rsp_ready_i |=> r_rsp_valid_o && $stable(r_rsp_status_o))
        else $error("Read response dropped or changed before it was taken");

    w_rsp_hold: assert property (@(posedge clk_i) disable iff (reset_i)
        w_rsp_valid_o && !w_rsp_ready_i |=> w_rsp_valid_o)
        else $error("Write response dropped before it was taken");

    // A beat always carries at least one byte
    dst_strb_set: assert property (@(posedge clk_i) disable iff (reset_i)
        dst_valid_o |-> dst_strb_o != '0)
        else $error("Destination beat offered with an empty strobe");

endmodule

bind idma_stream_transport idma_stream_transport_sva u_sva (.*);

/* idma_stream_transport.sv */
// Stream-to-stream transport with byte realignment, one source and one sink
// Read and write requests describe the same bytes and may overlap in time
// The write response marks the end of a transfer; latency is not fixed

`timescale 1ns/1ps

module idma_stream_transport
    import transport_cfg_pkg::*;
    import transport_status_pkg::*;
(
    input  logic    clk_i,
    input  logic    reset_i,

    // Read request and response
    input  offset_t r_req_offset_i,
    input  offset_t r_req_tailer_i,
    input  offset_t r_req_shift_i,
    input  beats_t  r_req_beats_i,
    input  logic    r_req_valid_i,
    output logic    r_req_ready_o,
    output status_t r_rsp_status_o,
    output logic    r_rsp_valid_o,
    input  logic    r_rsp_ready_i,

    // Write request and response
    input  offset_t w_req_offset_i,
    input  offset_t w_req_tailer_i,
    input  beats_t  w_req_beats_i,
    input  logic    w_req_valid_i,
    output logic    w_req_ready_o,
    output logic    w_rsp_valid_o,
    input  logic    w_rsp_ready_i,

    // Source stream
    input  data_t   src_data_i,
    input  logic    src_last_i,
    input  logic    src_valid_i,
    output logic    src_ready_o,

    // Destination stream
    output data_t   dst_data_o,
    output strb_t   dst_strb_o,
    output logic    dst_last_o,
    output logic    dst_valid_o,
    input  logic    dst_ready_i,

    output logic    r_busy_o,
    output logic    w_busy_o,
    output logic    buffer_busy_o
);

    // Bytes already in their destination lanes
    byte_t [STRB_WIDTH-1:0] lane_in_data;
    strb_t                  lane_in_valid;
    strb_t                  lane_in_ready;

    byte_t [STRB_WIDTH-1:0] lane_out_data;
    strb_t                  lane_out_valid;
    strb_t                  lane_out_ready;

    // ----------------------------------------
    // Read side
    // ----------------------------------------
    stream_read_port i_stream_read_port (
        .clk_i           ( clk_i          ),
        .reset_i         ( reset_i        ),
        .r_req_offset_i  ( r_req_offset_i ),
        .r_req_tailer_i  ( r_req_tailer_i ),
        .r_req_shift_i   ( r_req_shift_i  ),
        .r_req_beats_i   ( r_req_beats_i  ),
        .r_req_valid_i   ( r_req_valid_i  ),
        .r_req_ready_o   ( r_req_ready_o  ),
        .r_rsp_status_o  ( r_rsp_status_o ),
        .r_rsp_valid_o   ( r_rsp_valid_o  ),
        .r_rsp_ready_i   ( r_rsp_ready_i  ),
        .src_data_i      ( src_data_i     ),
        .src_last_i      ( src_last_i     ),
        .src_valid_i     ( src_valid_i    ),
        .src_ready_o     ( src_ready_o    ),
        .lane_in_data_o  ( lane_in_data   ),
        .lane_in_valid_o ( lane_in_valid  ),
        .lane_in_ready_i ( lane_in_ready  ),
        .r_busy_o        ( r_busy_o       )
    );

    // ----------------------------------------
    // Reorder buffer
    // ----------------------------------------
    byte_lane_buffer i_byte_lane_buffer (
        .clk_i            ( clk_i          ),
        .reset_i          ( reset_i        ),
        .lane_in_data_i   ( lane_in_data   ),
        .lane_in_valid_i  ( lane_in_valid  ),
        .lane_in_ready_o  ( lane_in_ready  ),
        .lane_out_data_o  ( lane_out_data  ),
        .lane_out_valid_o ( lane_out_valid ),
        .lane_out_ready_i ( lane_out_ready ),
        .buffer_busy_o    ( buffer_busy_o  )
    );

    // ----------------------------------------
    // Write side
    // ----------------------------------------
    stream_write_port i_stream_write_port (
        .clk_i            ( clk_i          ),
        .reset_i          ( reset_i        ),
        .w_req_offset_i   ( w_req_offset_i ),
        .w_req_tailer_i   ( w_req_tailer_i ),
        .w_req_beats_i    ( w_req_beats_i  ),
        .w_req_valid_i    ( w_req_valid_i  ),
        .w_req_ready_o    ( w_req_ready_o  ),
        .w_rsp_valid_o    ( w_rsp_valid_o  ),
        .w_rsp_ready_i    ( w_rsp_ready_i  ),
        .lane_out_data_i  ( lane_out_data  ),
        .lane_out_valid_i ( lane_out_valid ),
        .lane_out_ready_o ( lane_out_ready ),
        .dst_data_o       ( dst_data_o     ),
        .dst_strb_o       ( dst_strb_o     ),
        .dst_last_o       ( dst_last_o     ),
        .dst_valid_o      ( dst_valid_o    ),
        .dst_ready_i      ( dst_ready_i    ),
        .w_busy_o         ( w_busy_o       )
    );

endmodule

/* stream_write_port.sv */
// Write side of the transport; one request in flight at a time
// A beat is offered once every lane of its strobe mask holds a byte
// Lanes outside the mask are driven as zero on dst_data_o

`timescale 1ns/1ps

module stream_write_port
    import transport_cfg_pkg::*;
(
    input  logic                   clk_i,
    input  logic                   reset_i,

    input  offset_t                w_req_offset_i,
    input  offset_t                w_req_tailer_i,
    input  beats_t                 w_req_beats_i,
    input  logic                   w_req_valid_i,
    output logic                   w_req_ready_o,

    output logic                   w_rsp_valid_o,
    input  logic                   w_rsp_ready_i,

    input  byte_t [STRB_WIDTH-1:0] lane_out_data_i,
    input  strb_t                  lane_out_valid_i,
    output strb_t                  lane_out_ready_o,

    output data_t                  dst_data_o,
    output strb_t                  dst_strb_o,
    output logic                   dst_last_o,
    output logic                   dst_valid_o,
    input  logic                   dst_ready_i,

    output logic                   w_busy_o
);

    logic    active_q;
    logic    rsp_valid_q;
    beats_t  beat_cnt_q;

    // Request fields held for the whole transfer
    offset_t offset_q;
    offset_t tailer_q;
    beats_t  beats_q;

    logic    req_fire;
    logic    dst_fire;
    logic    last_beat;
    strb_t   dst_mask;

    assign req_fire  = w_req_valid_i && w_req_ready_o;
    assign last_beat = (beat_cnt_q == beats_q);
    assign dst_mask  = lane_mask(offset_q, tailer_q, beat_cnt_q == '0, last_beat);

    // ----------------------------------------
    // Beat gathering
    // ----------------------------------------
    assign dst_valid_o = active_q && (&(lane_out_valid_i | ~dst_mask));
    assign dst_fire    = dst_valid_o && dst_ready_i;

    always_comb begin
        for (int unsigned l = 0; l < STRB_WIDTH; l++) begin
            dst_data_o[l*8 +: 8] = dst_mask[l] ? lane_out_data_i[l] : 8'h00;
        end
    end

    assign dst_strb_o = dst_mask;
    assign dst_last_o = last_beat;

    // Only the masked lanes are consumed by a beat
    assign lane_out_ready_o = dst_mask & {STRB_WIDTH{dst_fire}};

    // ----------------------------------------
    // Sequencing
    // ----------------------------------------
    always_ff @(posedge clk_i) begin
        if (reset_i) begin
            active_q    <= 1'b0;
            rsp_valid_q <= 1'b0;
            beat_cnt_q  <= '0;
        end else begin
            if (req_fire) begin
                active_q   <= 1'b1;
                beat_cnt_q <= '0;
            end
            if (dst_fire) begin
                if (last_beat) begin
                    active_q    <= 1'b0;
                    rsp_valid_q <= 1'b1;
                end else begin
                    beat_cnt_q  <= beat_cnt_q + 1'b1;
                end
            end
            if (rsp_valid_q && w_rsp_ready_i) begin
                rsp_valid_q <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk_i) begin
        if (req_fire) begin
            offset_q <= w_req_offset_i;
            tailer_q <= w_req_tailer_i;
            beats_q  <= w_req_beats_i;
        end
    end

    assign w_req_ready_o = !(active_q || rsp_valid_q);
    assign w_rsp_valid_o = rsp_valid_q;
    assign w_busy_o      = active_q || rsp_valid_q;

endmodule

/* byte_lane_buffer.sv */
// Reorder buffer; one independent FIFO of BUFFER_DEPTH bytes per lane
// No bypass, a pushed byte shows at the output one cycle later
// A full lane stays not-ready even while it is being popped

`timescale 1ns/1ps

module byte_lane_buffer
    import transport_cfg_pkg::*;
(
    input  logic                   clk_i,
    input  logic                   reset_i,

    input  byte_t [STRB_WIDTH-1:0] lane_in_data_i,
    input  strb_t                  lane_in_valid_i,
    output strb_t                  lane_in_ready_o,

    output byte_t [STRB_WIDTH-1:0] lane_out_data_o,
    output strb_t                  lane_out_valid_o,
    input  strb_t                  lane_out_ready_i,

    output logic                   buffer_busy_o
);

    byte_t                 mem_q [STRB_WIDTH][BUFFER_DEPTH];
    ptr_t [STRB_WIDTH-1:0] wr_ptr_q;
    ptr_t [STRB_WIDTH-1:0] rd_ptr_q;
    cnt_t [STRB_WIDTH-1:0] count_q;

    strb_t push;
    strb_t pop;

    function automatic ptr_t ptr_inc(ptr_t ptr);
        return (ptr == ptr_t'(BUFFER_DEPTH - 1)) ? '0 : ptr + 1'b1;
    endfunction

    assign push = lane_in_valid_i & lane_in_ready_o;
    assign pop  = lane_out_valid_o & lane_out_ready_i;

    // ----------------------------------------
    // Lane status and read data
    // ----------------------------------------
    always_comb begin
        for (int unsigned l = 0; l < STRB_WIDTH; l++) begin
            lane_in_ready_o[l]  = (count_q[l] != cnt_t'(BUFFER_DEPTH));
            lane_out_valid_o[l] = (count_q[l] != '0);
            lane_out_data_o[l]  = mem_q[l][rd_ptr_q[l]];
        end
    end

    assign buffer_busy_o = |lane_out_valid_o;

    // ----------------------------------------
    // Pointers and fill levels
    // ----------------------------------------
    always_ff @(posedge clk_i) begin
        if (reset_i) begin
            wr_ptr_q <= '0;
            rd_ptr_q <= '0;
            count_q  <= '0;
        end else begin
            for (int unsigned l = 0; l < STRB_WIDTH; l++) begin
                if (push[l]) begin
                    wr_ptr_q[l] <= ptr_inc(wr_ptr_q[l]);
                end
                if (pop[l]) begin
                    rd_ptr_q[l] <= ptr_inc(rd_ptr_q[l]);
                end
                // Simultaneous push and pop leaves the level unchanged
                if (push[l] && !pop[l]) begin
                    count_q[l] <= count_q[l] + 1'b1;
                end else if (pop[l] && !push[l]) begin
                    count_q[l] <= count_q[l] - 1'b1;
                end
            end
        end
    end

    // Storage
    always_ff @(posedge clk_i) begin
        for (int unsigned l = 0; l < STRB_WIDTH; l++) begin
            if (push[l]) begin
                mem_q[l][wr_ptr_q[l]] <= lane_in_data_i[l];
            end
        end
    end

endmodule

/* stream_read_port.sv */
// Read side of the transport; one request in flight at a time
// A source beat is taken only when every lane it feeds has room
// The beat count comes from the request, src_last_i is only checked

`timescale 1ns/1ps

module stream_read_port
    import transport_cfg_pkg::*;
    import transport_status_pkg::*;
(
    input  logic                   clk_i,
    input  logic                   reset_i,

    input  offset_t                r_req_offset_i,
    input  offset_t                r_req_tailer_i,
    input  offset_t                r_req_shift_i,
    input  beats_t                 r_req_beats_i,
    input  logic                   r_req_valid_i,
    output logic                   r_req_ready_o,

    output status_t                r_rsp_status_o,
    output logic                   r_rsp_valid_o,
    input  logic                   r_rsp_ready_i,

    input  data_t                  src_data_i,
    input  logic                   src_last_i,
    input  logic                   src_valid_i,
    output logic                   src_ready_o,

    output byte_t [STRB_WIDTH-1:0] lane_in_data_o,
    output strb_t                  lane_in_valid_o,
    input  strb_t                  lane_in_ready_i,

    output logic                   r_busy_o
);

    logic    active_q;
    logic    rsp_valid_q;
    beats_t  beat_cnt_q;
    status_t status_q;
    status_t status_d;

    // Request fields held for the whole transfer
    offset_t offset_q;
    offset_t tailer_q;
    offset_t shift_q;
    beats_t  beats_q;

    logic    req_fire;
    logic    src_fire;
    logic    last_beat;
    strb_t   src_mask;
    strb_t   ready_src;
    offset_t unshift;

    byte_t [2*STRB_WIDTH-1:0] data_dbl;

    assign req_fire  = r_req_valid_i && r_req_ready_o;
    assign last_beat = (beat_cnt_q == beats_q);
    assign src_mask  = lane_mask(offset_q, tailer_q, beat_cnt_q == '0, last_beat);

    // ----------------------------------------
    // Barrel rotation
    // ----------------------------------------
    // Source lane L lands in buffer lane (L - shift) mod STRB_WIDTH
    assign data_dbl       = {src_data_i, src_data_i} >> {shift_q, 3'b000};
    assign lane_in_data_o = data_dbl[STRB_WIDTH-1:0];

    // Readies travel back the other way
    assign unshift   = -shift_q;
    assign ready_src = strb_t'({lane_in_ready_i, lane_in_ready_i} >> unshift);

    assign src_ready_o = active_q && (&(ready_src | ~src_mask));
    assign src_fire    = src_valid_i && src_ready_o;

    // All needed lanes push together or not at all
    assign lane_in_valid_o = strb_t'({src_mask, src_mask} >> shift_q)
                             & {STRB_WIDTH{src_fire}};

    // ----------------------------------------
    // Last-beat check
    // ----------------------------------------
    always_comb begin
        status_d = status_q;
        if (src_fire && status_q == STATUS_OK) begin
            if (src_last_i && !last_beat) begin
                status_d = STATUS_EARLY_LAST;
            end else if (last_beat && !src_last_i) begin
                status_d = STATUS_LATE_LAST;
            end
        end
    end

    // ----------------------------------------
    // Sequencing
    // ----------------------------------------
    always_ff @(posedge clk_i) begin
        if (reset_i) begin
            active_q    <= 1'b0;
            rsp_valid_q <= 1'b0;
            beat_cnt_q  <= '0;
            status_q    <= STATUS_OK;
        end else begin
            if (req_fire) begin
                active_q   <= 1'b1;
                beat_cnt_q <= '0;
                status_q   <= STATUS_OK;
            end else begin
                status_q   <= status_d;
            end
            if (src_fire) begin
                if (last_beat) begin
                    active_q    <= 1'b0;
                    rsp_valid_q <= 1'b1;
                end else begin
                    beat_cnt_q  <= beat_cnt_q + 1'b1;
                end
            end
            if (rsp_valid_q && r_rsp_ready_i) begin
                rsp_valid_q <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk_i) begin
        if (req_fire) begin
            offset_q <= r_req_offset_i;
            tailer_q <= r_req_tailer_i;
            shift_q  <= r_req_shift_i;
            beats_q  <= r_req_beats_i;
        end
    end

    assign r_req_ready_o  = !(active_q || rsp_valid_q);
    assign r_rsp_valid_o  = rsp_valid_q;
    assign r_rsp_status_o = status_q;
    assign r_busy_o       = active_q || rsp_valid_q;

endmodule

/* transport_status_pkg.sv */
// Read response status codes
// Only the first last-mark mismatch of a transfer is reported

package transport_status_pkg;

    typedef logic [1:0] status_t;

    // Transfer ended where the request said it would
    localparam status_t STATUS_OK         = 2'd0;

    // Source marked last before the final beat
    localparam status_t STATUS_EARLY_LAST = 2'd1;

    // Final beat arrived without a last mark
    localparam status_t STATUS_LATE_LAST  = 2'd2;

endpackage

/* transport_cfg_pkg.sv */
// Datapath widths and types shared by the transport, fixed at a 32-bit bus
// Lane FIFO depth of 3 lets overlapping requests keep the stream moving
// lane_mask implements the offset/tailer rule for both ports

package transport_cfg_pkg;

    // ----------------------------------------
    // Sizes
    // ----------------------------------------
    localparam int unsigned DATA_WIDTH   = 32;
    localparam int unsigned STRB_WIDTH   = DATA_WIDTH / 8;
    localparam int unsigned OFFSET_WIDTH = $clog2(STRB_WIDTH);
    localparam int unsigned BEATS_WIDTH  = 8;
    localparam int unsigned BUFFER_DEPTH = 3;

    // Lane FIFO pointer and fill level
    localparam int unsigned PTR_WIDTH    = $clog2(BUFFER_DEPTH);
    localparam int unsigned CNT_WIDTH    = $clog2(BUFFER_DEPTH + 1);

    // ----------------------------------------
    // Vector types
    // ----------------------------------------
    typedef logic [7:0]              byte_t;
    typedef logic [DATA_WIDTH-1:0]   data_t;
    typedef logic [STRB_WIDTH-1:0]   strb_t;
    typedef logic [OFFSET_WIDTH-1:0] offset_t;
    typedef logic [BEATS_WIDTH-1:0]  beats_t;
    typedef logic [PTR_WIDTH-1:0]    ptr_t;
    typedef logic [CNT_WIDTH-1:0]    cnt_t;

    // Valid lanes of one beat
    // A tailer of zero keeps every lane of the last beat
    function automatic strb_t lane_mask(offset_t offset, offset_t tailer,
                                        logic first, logic last);
        strb_t mask;
        for (int unsigned l = 0; l < STRB_WIDTH; l++) begin
            mask[l] = (!first || l >= offset) &&
                      (!last || tailer == '0 || l < tailer);
        end
        return mask;
    endfunction

endpackage
